/* common/uart_pkg.sv */
// Fixed 8N1 frame, MSB first; the bit period comes from outside and is shared by both directions.
package uart_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sizes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int PERIOD_BITS    = 20;                 // Bit period counter width.
	localparam int DATA_BITS      = 8;
	localparam int BIT_IDX_BITS   = $clog2(DATA_BITS);  // Selects one data bit.
	localparam int FILTER_LEN     = 8;                  // Equal samples to move the line.
	localparam int FIFO_DEPTH     = 4;
	localparam int FIFO_ADDR_BITS = 2;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [PERIOD_BITS-1:0] period_t;  // Cycles per bit, unsigned.

	typedef struct packed {
		logic                 vld;   // One-cycle strobe.
		logic [DATA_BITS-1:0] data;  // Held after the strobe.
	} byte_frame_t;

	// Frame states, data states are consecutive from D7 down to D0.
	typedef enum logic [3:0] {
		ST_IDLE  = 4'h0,
		ST_START = 4'h1,
		ST_D7    = 4'h2,
		ST_D6    = 4'h3,
		ST_D5    = 4'h4,
		ST_D4    = 4'h5,
		ST_D3    = 4'h6,
		ST_D2    = 4'h7,
		ST_D1    = 4'h8,
		ST_D0    = 4'h9,
		ST_STOP  = 4'ha,
		ST_DONE  = 4'hf   // Receiver only.
	} uart_state_t;

endpackage

/* design/byte_fifo.sv */
// Writes on every strobe and drops a write when full; pops one byte per transmitter idle window.
module byte_fifo (
	input  logic                           clk_sys,
	input  logic                           rst_n,
	input  uart_pkg::byte_frame_t          rx_frame,
	input  logic                           tx_busy,
	output logic                           tx_start,
	output logic [uart_pkg::DATA_BITS-1:0] tx_data
);

	logic [uart_pkg::DATA_BITS-1:0]      mem [uart_pkg::FIFO_DEPTH];
	logic [uart_pkg::FIFO_ADDR_BITS-1:0] wr_ptr;
	logic [uart_pkg::FIFO_ADDR_BITS-1:0] rd_ptr;
	logic [uart_pkg::FIFO_ADDR_BITS:0]   count;
	logic                                push;
	logic                                pop;

	assign push = rx_frame.vld && (count != (uart_pkg::FIFO_ADDR_BITS+1)'(uart_pkg::FIFO_DEPTH));

	// Busy shows up one cycle late, so skip the cycle after a start.
	assign pop = (count != '0) && !tx_busy && !tx_start;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pointers and count
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			tx_start <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth.
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			tx_start <= pop;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Storage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_sys) begin
		if (push) begin
			mem[wr_ptr] <= rx_frame.data;
		end
		if (pop) begin
			tx_data <= mem[rd_ptr];  // Valid with tx_start.
		end
	end

endmodule

/* design/uart_echo_top.sv */
// Echoes each received byte in arrival order; both directions run from one external bit period.
module uart_echo_top (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  rx,
	input  uart_pkg::period_t     tbit_period,
	output logic                  tx,
	output uart_pkg::byte_frame_t rx_frame
);

	logic                           tx_busy;
	logic                           tx_start;
	logic [uart_pkg::DATA_BITS-1:0] tx_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Receive, buffer, transmit
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	uart_rx i_uart_rx (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.rx          (rx),
		.tbit_period (tbit_period),
		.rx_frame    (rx_frame)   // Also brought out for observation.
	);

	byte_fifo i_byte_fifo (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.rx_frame (rx_frame),
		.tx_busy  (tx_busy),
		.tx_start (tx_start),
		.tx_data  (tx_data)
	);

	uart_tx i_uart_tx (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.tbit_period (tbit_period),
		.tx_start    (tx_start),
		.tx_data     (tx_data),
		.tx          (tx),
		.tx_busy     (tx_busy)
	);

endmodule

/* files.f */
common/uart_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
design/byte_fifo.sv
design/uart_echo_top.sv
tests/tb_uart_echo.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f files.f --top-module tb_uart_echo -o sim_uart_echo

output="$(./obj_dir/sim_uart_echo)"
printf '%s\n' "$output"

if grep -Fxq '>>> PASS' <<< "$output"; then
	exit 0
else
	exit 1
fi

/* tests/tb_uart_echo.sv */
// Periods must be at least 16 cycles and change only between streams; every wait has a timeout.
module tb_uart_echo;

	timeunit 1ns;
	timeprecision 100ps;

	logic                  clk_sys;
	logic                  rst_n;
	logic                  rx;
	uart_pkg::period_t     tbit_period;
	logic                  tx;
	uart_pkg::byte_frame_t rx_frame;

	logic [31:0] lcg_state;
	logic [7:0]  rx_q[$];      // Bytes awaiting a receiver strobe.
	logic [7:0]  echo_q[$];    // Bytes awaiting an echo on tx.
	logic        mon_active;
	string       test_name;
	int          value_errors;
	int          protocol_errors;
	int          timeout_errors;

	uart_echo_top i_uart_echo_top (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.rx          (rx),
		.tbit_period (tbit_period),
		.tx          (tx),
		.rx_frame    (rx_frame)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_byte(input string what, input logic [7:0] expected,
		input logic [7:0] actual);
		assert (actual === expected) else begin
			value_errors++;
			$display("mismatch %s %s: expected %02h actual %02h", test_name, what,
				expected, actual);
		end
	endtask

	// Start bit, D7..D0 and stop bit each last one period.
	task automatic send_frame(input logic [7:0] value);
		logic [9:0] bits;
		int         n;
		bits = {1'b0, value, 1'b1};
		rx_q.push_back(value);
		echo_q.push_back(value);
		for (n = 0; n < 10; n++) begin
			rx   <= bits[9];
			bits = {bits[8:0], 1'b1};
			repeat (tbit_period) @(posedge clk_sys);
		end
	endtask

	task automatic check_quiet(input logic [31:0] cycles);
		logic [31:0] n;
		for (n = 32'd0; n < cycles; n++) begin
			@(posedge clk_sys);
			check_byte("strobe", 8'h00, {7'd0, rx_frame.vld});
			check_byte("tx level", 8'h01, {7'd0, tx});
		end
	endtask

	task automatic wait_drained(input logic [31:0] limit);
		logic [31:0] cycles;
		cycles = 32'd0;
		while ((rx_q.size() != 0 || echo_q.size() != 0 || mon_active) && cycles < limit) begin
			@(posedge clk_sys);
			cycles++;
		end
		assert (rx_q.size() == 0 && echo_q.size() == 0 && !mon_active) else begin
			timeout_errors++;
			$display("%s: timed out with %0d bytes not received and %0d bytes not echoed",
				test_name, rx_q.size(), echo_q.size());
			rx_q.delete();
			echo_q.delete();
		end
	endtask

	task automatic run_stream(input string name, input int frames, input logic with_gaps);
		logic [31:0] rnd;
		logic [31:0] gap;
		int          n;
		test_name = name;
		for (n = 0; n < frames; n++) begin
			rnd = next_rand();
			gap = with_gaps ? (rnd[15:0] % (32'(tbit_period) * 32'd4)) : 32'd0;
			repeat (gap) @(posedge clk_sys);
			send_frame(rnd[31:24]);
		end
		wait_drained(32'(tbit_period) * 32'd60 + 32'd200);
	endtask

	task automatic check_glitches(input int pulses);
		logic [31:0] rnd;
		int          n;
		test_name = "glitch_reject";
		for (n = 0; n < pulses; n++) begin
			rnd = next_rand();
			rx  <= 1'b0;
			repeat (32'd1 + rnd[7:0] % 32'd6) @(posedge clk_sys);  // 1 to 6 cycles low.
			rx  <= 1'b1;
			check_quiet(32'd10 + rnd[23:16] % 32'd20);
		end
		check_quiet(32'(tbit_period) * 32'd30);  // Three frame times.
	endtask

	task automatic change_period(input int cycles);
		tbit_period <= uart_pkg::period_t'(cycles);
		repeat (4) @(posedge clk_sys);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Receive checker and tx monitor
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(posedge clk_sys) begin : rx_checker
		logic [7:0] expected;
		if (rst_n && rx_frame.vld) begin
			assert (rx_q.size() != 0) else begin
				protocol_errors++;
				$display("%s: receiver strobe with byte %02h but nothing was sent",
					test_name, rx_frame.data);
			end
			if (rx_q.size() != 0) begin
				expected = rx_q.pop_front();
				check_byte("rx byte", expected, rx_frame.data);
			end
		end
	end

	// Called one cycle into the start bit. Samples every bit at its middle.
	task automatic capture_tx_frame();
		uart_pkg::period_t per;
		logic [9:0]        bits;
		logic [7:0]        expected;
		int                n;
		per        = tbit_period;
		mon_active = 1'b1;
		repeat (per >> 1) @(posedge clk_sys);
		bits = {9'd0, tx};
		for (n = 0; n < 9; n++) begin
			repeat (per) @(posedge clk_sys);
			bits = {bits[8:0], tx};
		end
		check_byte("tx start bit", 8'h00, {7'd0, bits[9]});
		check_byte("tx stop bit", 8'h01, {7'd0, bits[0]});
		assert (echo_q.size() != 0) else begin
			protocol_errors++;
			$display("%s: byte %02h appeared on tx but no byte was outstanding",
				test_name, bits[8:1]);
		end
		if (echo_q.size() != 0) begin
			expected = echo_q.pop_front();
			check_byte("echo byte", expected, bits[8:1]);
		end
		repeat (per - (per >> 1)) @(posedge clk_sys);  // Rest of the stop bit.
		mon_active = 1'b0;
	endtask

	initial begin : tx_monitor
		logic tx_prev;
		tx_prev    = 1'b1;
		mon_active = 1'b0;
		forever begin
			@(posedge clk_sys);
			if (rst_n && tx_prev && !tx) begin
				capture_tx_frame();
			end
			tx_prev = tx;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin : main
		lcg_state       = 32'h07ce_db63;
		value_errors    = 0;
		protocol_errors = 0;
		timeout_errors  = 0;
		test_name       = "reset_state";
		rst_n           = 1'b0;
		rx              = 1'b1;
		tbit_period     = uart_pkg::period_t'(16);
		repeat (2) @(posedge clk_sys);
		rst_n <= 1'b1;
		check_quiet(32'd50);
		run_stream("receive_echo_p16", 40, 1'b1);
		run_stream("back_to_back", 12, 1'b0);
		check_glitches(8);
		change_period(33);
		run_stream("receive_echo_p33", 40, 1'b1);
		change_period(100);
		run_stream("receive_echo_p100", 40, 1'b1);
		test_name = "final_idle";
		check_quiet(32'(tbit_period) * 32'd20);  // No late or extra bytes.
		$display("errors: value %0d, protocol %0d, timeout %0d",
			value_errors, protocol_errors, timeout_errors);
		if (value_errors + protocol_errors + timeout_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* uart/uart_rx.sv */
// Period held per frame and above 8 cycles, or single bits never pass the filter; stop bit unchecked.
module uart_rx (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  rx,
	input  uart_pkg::period_t     tbit_period,
	output uart_pkg::byte_frame_t rx_frame
);

	logic [uart_pkg::FILTER_LEN-1:0] rx_shift;
	logic                            rx_filt;
	logic                            rx_filt_q;
	logic                            rx_falling;
	logic                            start_det;
	uart_pkg::uart_state_t           state;
	uart_pkg::period_t               bit_cnt;
	uart_pkg::period_t               mid_point;
	logic                            in_bit;
	logic                            in_data;
	logic                            finish_bit;
	logic [uart_pkg::DATA_BITS-1:0]  rx_bits;
	logic                            frame_vld;
	logic [uart_pkg::DATA_BITS-1:0]  frame_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Glitch filter and edge detect
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rx_shift  <= '1;
			rx_filt   <= 1'b1;
			rx_filt_q <= 1'b1;
		end else begin
			rx_shift  <= {rx_shift[uart_pkg::FILTER_LEN-2:0], rx};
			if (&rx_shift) begin
				rx_filt <= 1'b1;
			end else if (~|rx_shift) begin
				rx_filt <= 1'b0;
			end
			rx_filt_q <= rx_filt;
		end
	end

	assign rx_falling = !rx_filt && rx_filt_q;

	// A new start may follow DONE directly on back-to-back frames.
	assign start_det = rx_falling && ((state == uart_pkg::ST_IDLE) ||
		(state == uart_pkg::ST_DONE));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Frame FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= uart_pkg::ST_IDLE;
		end else begin
			case (state)
				uart_pkg::ST_IDLE, uart_pkg::ST_DONE: begin
					state <= start_det ? uart_pkg::ST_START : uart_pkg::ST_IDLE;
				end
				uart_pkg::ST_START, uart_pkg::ST_D7, uart_pkg::ST_D6,
				uart_pkg::ST_D5, uart_pkg::ST_D4, uart_pkg::ST_D3,
				uart_pkg::ST_D2, uart_pkg::ST_D1, uart_pkg::ST_D0: begin
					if (finish_bit) begin
						state <= uart_pkg::uart_state_t'(state + 4'd1);  // Next bit.
					end
				end
				uart_pkg::ST_STOP: begin
					if (finish_bit) begin
						state <= uart_pkg::ST_DONE;
					end
				end
				default: state <= uart_pkg::ST_IDLE;
			endcase
		end
	end

	assign in_bit  = (state >= uart_pkg::ST_START) && (state <= uart_pkg::ST_STOP);
	assign in_data = (state >= uart_pkg::ST_D7) && (state <= uart_pkg::ST_D0);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bit timer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= '0;
		end else if (start_det) begin
			bit_cnt <= uart_pkg::period_t'(1);  // Edge cycle is the first start sample.
		end else if (finish_bit || !in_bit) begin
			bit_cnt <= '0;
		end else begin
			bit_cnt <= bit_cnt + uart_pkg::period_t'(1);
		end
	end

	assign finish_bit = in_bit && (bit_cnt == tbit_period - uart_pkg::period_t'(1));
	assign mid_point  = (tbit_period >> 1) - uart_pkg::period_t'(1);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Mid-bit sampling and output
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_sys) begin
		if (in_data && (bit_cnt == mid_point)) begin
			rx_bits <= {rx_bits[uart_pkg::DATA_BITS-2:0], rx_filt};  // MSB arrives first.
		end
		if (state == uart_pkg::ST_DONE) begin
			frame_data <= rx_bits;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			frame_vld <= 1'b0;
		end else begin
			frame_vld <= (state == uart_pkg::ST_DONE);
		end
	end

	assign rx_frame = '{vld: frame_vld, data: frame_data};

endmodule

/* uart/uart_tx.sv */
// Period held per frame and at least 4; tx_start is taken only while tx_busy is low.
module uart_tx (
	input  logic                           clk_sys,
	input  logic                           rst_n,
	input  uart_pkg::period_t              tbit_period,
	input  logic                           tx_start,
	input  logic [uart_pkg::DATA_BITS-1:0] tx_data,
	output logic                           tx,
	output logic                           tx_busy
);

	uart_pkg::uart_state_t                 state;
	uart_pkg::uart_state_t                 state_nxt;
	uart_pkg::period_t                     bit_cnt;
	logic                                  in_bit;
	logic                                  finish_bit;
	logic [uart_pkg::DATA_BITS-1:0]        tx_byte;
	logic [3:0]                            state_ofs;
	logic [uart_pkg::BIT_IDX_BITS-1:0]     bit_idx;
	logic                                  line_nxt;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Frame FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		state_nxt = state;
		case (state)
			uart_pkg::ST_IDLE: begin
				if (tx_start) begin
					state_nxt = uart_pkg::ST_START;
				end
			end
			uart_pkg::ST_START, uart_pkg::ST_D7, uart_pkg::ST_D6,
			uart_pkg::ST_D5, uart_pkg::ST_D4, uart_pkg::ST_D3,
			uart_pkg::ST_D2, uart_pkg::ST_D1, uart_pkg::ST_D0: begin
				if (finish_bit) begin
					state_nxt = uart_pkg::uart_state_t'(state + 4'd1);
				end
			end
			uart_pkg::ST_STOP: begin
				if (finish_bit) begin
					state_nxt = uart_pkg::ST_IDLE;
				end
			end
			default: state_nxt = uart_pkg::ST_IDLE;
		endcase
	end

	// Line level for the coming state, so tx leaves a flop.
	always_comb begin
		state_ofs = uart_pkg::ST_D0 - state_nxt;
		bit_idx   = state_ofs[uart_pkg::BIT_IDX_BITS-1:0];  // D7 maps to bit 7.
		if (state_nxt == uart_pkg::ST_START) begin
			line_nxt = 1'b0;
		end else if (state_nxt inside {[uart_pkg::ST_D7:uart_pkg::ST_D0]}) begin
			line_nxt = tx_byte[bit_idx];
		end else begin
			line_nxt = 1'b1;  // Idle and stop.
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= uart_pkg::ST_IDLE;
			tx    <= 1'b1;
		end else begin
			state <= state_nxt;
			tx    <= line_nxt;
		end
	end

	always_ff @(posedge clk_sys) begin
		if ((state == uart_pkg::ST_IDLE) && tx_start) begin
			tx_byte <= tx_data;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bit timer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign in_bit     = (state != uart_pkg::ST_IDLE);
	assign finish_bit = in_bit && (bit_cnt == tbit_period - uart_pkg::period_t'(1));

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= '0;
		end else if (finish_bit || !in_bit) begin
			bit_cnt <= '0;
		end else begin
			bit_cnt <= bit_cnt + uart_pkg::period_t'(1);
		end
	end

	assign tx_busy = in_bit;  // Drops the cycle after stop.

endmodule
